//--- Bender.yml
package:
  name: dmgCore

sources:
  - target: rtl
    files:
      - rtl/dmgCorePkg.sv
      - rtl/dmgStageIf.sv
      - rtl/dmgDecodeStage.sv
      - rtl/dmgRegisterFile.sv
      - rtl/dmgAlu.sv
      - rtl/dmgExecuteStage.sv
      - rtl/dmgCoreTop.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tbDmgCore.sv

//--- dmgCore.f
+incdir+testbench
rtl/dmgCorePkg.sv
rtl/dmgStageIf.sv
rtl/dmgDecodeStage.sv
rtl/dmgRegisterFile.sv
rtl/dmgAlu.sv
rtl/dmgExecuteStage.sv
rtl/dmgCoreTop.sv
testbench/tbDmgCore.sv

//--- rtl/dmgAlu.sv
`timescale 1ns/100ps

module dmgAlu
(
  input  dmgCorePkg::aluOp_t op,
  input  logic [7:0]         accIn,
  input  logic [7:0]         srcIn,
  input  logic [7:0]         dstIn,
  input  logic [7:0]         flagsIn,
  output logic [7:0]         result,
  output logic [7:0]         flagsOut
);

  logic       carryIn;
  logic [4:0] addLow;
  logic [8:0] addFull;
  logic [4:0] subLow;
  logic [8:0] subFull;
  logic       z;
  logic       n;
  logic       h;
  logic       c;

  // ------------------------------------------------------------
  // Adder and subtractor, shared by ADD/ADC and SUB/CP
  // ------------------------------------------------------------
  assign carryIn = (op == dmgCorePkg::aluAdc) ? flagsIn[dmgCorePkg::flagC] : 1'b0;
  assign addLow  = accIn[3:0] + srcIn[3:0] + carryIn;
  assign addFull = accIn + srcIn + carryIn;
  assign subLow  = accIn[3:0] - srcIn[3:0];  // Bit 4 is the half borrow
  assign subFull = accIn - srcIn;

  always_comb
  begin
    result = srcIn;
    z      = flagsIn[dmgCorePkg::flagZ];
    n      = flagsIn[dmgCorePkg::flagN];
    h      = flagsIn[dmgCorePkg::flagH];
    c      = flagsIn[dmgCorePkg::flagC];
    case (op)
      dmgCorePkg::aluInc:
      begin
        result = dstIn + 8'd1;
        n      = 1'b0;
        h      = (result[3:0] == 4'h0);
      end
      dmgCorePkg::aluDec:
      begin
        result = dstIn - 8'd1;
        n      = 1'b1;
        h      = (result[3:0] == 4'hF);
      end
      dmgCorePkg::aluAdd, dmgCorePkg::aluAdc:
      begin
        result = addFull[7:0];
        n      = 1'b0;
        h      = addLow[4];
        c      = addFull[8];
      end
      dmgCorePkg::aluSub, dmgCorePkg::aluCp:
      begin
        result = subFull[7:0];  // CP discards it later
        n      = 1'b1;
        h      = subLow[4];
        c      = subFull[8];
      end
      dmgCorePkg::aluAnd:
      begin
        result = accIn & srcIn;
        n      = 1'b0;
        h      = 1'b1;
        c      = 1'b0;
      end
      dmgCorePkg::aluXor, dmgCorePkg::aluOr:
      begin
        result = (op == dmgCorePkg::aluXor) ? (accIn ^ srcIn) : (accIn | srcIn);
        n      = 1'b0;
        h      = 1'b0;
        c      = 1'b0;
      end
      default:
        result = srcIn;  // LD keeps every flag
    endcase
    if (op != dmgCorePkg::aluLd)
      z = (result == 8'h00);

    flagsOut                    = 8'h00;
    flagsOut[dmgCorePkg::flagZ] = z;
    flagsOut[dmgCorePkg::flagN] = n;
    flagsOut[dmgCorePkg::flagH] = h;
    flagsOut[dmgCorePkg::flagC] = c;
  end

endmodule

//--- rtl/dmgCorePkg.sv
package dmgCorePkg;

  // ------------------------------------------------------------
  // Register indices, in opcode order
  // ------------------------------------------------------------
  typedef logic [2:0] regIdx_t;

  localparam regIdx_t idxB   = 3'd0;
  localparam regIdx_t idxC   = 3'd1;
  localparam regIdx_t idxD   = 3'd2;
  localparam regIdx_t idxE   = 3'd3;
  localparam regIdx_t idxH   = 3'd4;
  localparam regIdx_t idxL   = 3'd5;
  localparam regIdx_t idxMem = 3'd6;  // (HL) operand, not stored
  localparam regIdx_t idxA   = 3'd7;

  // ------------------------------------------------------------
  // ALU operations
  // ------------------------------------------------------------
  typedef enum logic [3:0]
  {
    aluLd,
    aluInc,
    aluDec,
    aluAdd,
    aluAdc,
    aluSub,
    aluCp,
    aluAnd,
    aluXor,
    aluOr
  } aluOp_t;

  // Flag byte layout, low nibble always zero
  localparam int flagZ = 7;
  localparam int flagN = 6;
  localparam int flagH = 5;
  localparam int flagC = 4;

  localparam logic [7:0] cResetFlags = 8'hB0;

  // ------------------------------------------------------------
  // Decoded instruction record
  // ------------------------------------------------------------
  typedef struct packed
  {
    logic [7:0] opcode;
    aluOp_t     aluOp;
    regIdx_t    src;
    regIdx_t    dst;
    logic       writeDst;    // Clear for CP
    logic       writeFlags;  // Clear for LD
  } decodedOp_t;

endpackage

//--- rtl/dmgCoreTop.sv
`timescale 1ns/100ps

module dmgCoreTop
#(
  parameter logic [7:0] pResetFlags = dmgCorePkg::cResetFlags
)
(
  input  logic       iClock,
  input  logic       arstN,
  input  logic       opValid,
  output logic       opReady,
  input  logic [7:0] opCode,
  output logic       retValid,
  input  logic       retReady,
  output logic [7:0] retOpcode,
  output logic [7:0] retResult,
  output logic [7:0] retFlags
);

  dmgCorePkg::regIdx_t rdIdxA;
  dmgCorePkg::regIdx_t rdIdxB;
  dmgCorePkg::regIdx_t wrIdx;
  logic                wrEn;
  logic [7:0]          wrData;
  logic                flagsWe;
  logic [7:0]          newFlags;
  logic [7:0]          rdDataA;
  logic [7:0]          rdDataB;
  logic [7:0]          regA;
  logic [7:0]          flags;

  dmgStageIf stageLink ();

  dmgDecodeStage decode
  (
    .iClock (iClock),
    .arstN  (arstN),
    .opValid(opValid),
    .opReady(opReady),
    .opCode (opCode),
    .decOut (stageLink.source)
  );

  dmgExecuteStage execute
  (
    .iClock   (iClock),
    .arstN    (arstN),
    .decIn    (stageLink.sink),
    .rdIdxA   (rdIdxA),
    .rdIdxB   (rdIdxB),
    .wrEn     (wrEn),
    .wrIdx    (wrIdx),
    .wrData   (wrData),
    .flagsWe  (flagsWe),
    .newFlags (newFlags),
    .rdDataA  (rdDataA),
    .rdDataB  (rdDataB),
    .regA     (regA),
    .flags    (flags),
    .retValid (retValid),
    .retReady (retReady),
    .retOpcode(retOpcode),
    .retResult(retResult),
    .retFlags (retFlags)
  );

  dmgRegisterFile #(.pResetFlags(pResetFlags)) regFile
  (
    .iClock (iClock),
    .arstN  (arstN),
    .rdIdxA (rdIdxA),
    .rdIdxB (rdIdxB),
    .wrEn   (wrEn),
    .wrIdx  (wrIdx),
    .wrData (wrData),
    .flagsWe(flagsWe),
    .flagsIn(newFlags),
    .rdDataA(rdDataA),
    .rdDataB(rdDataB),
    .regA   (regA),
    .flags  (flags)
  );

endmodule

//--- rtl/dmgDecodeStage.sv
`timescale 1ns/100ps

module dmgDecodeStage
(
  input  logic       iClock,
  input  logic       arstN,
  input  logic       opValid,
  output logic       opReady,
  input  logic [7:0] opCode,
  dmgStageIf.source  decOut
);

  dmgCorePkg::decodedOp_t decoded;
  dmgCorePkg::decodedOp_t heldOp;
  logic                   heldValid;
  logic                   keepOp;

  // ------------------------------------------------------------
  // Opcode sorting
  // ------------------------------------------------------------
  always_comb
  begin
    decoded.opcode = opCode;
    decoded.aluOp  = dmgCorePkg::aluLd;
    decoded.src    = opCode[2:0];
    decoded.dst    = opCode[5:3];
    keepOp         = 1'b0;
    case (opCode[7:6])
      2'b01:  // LD r,r'
      begin
        keepOp = (opCode[5:3] != dmgCorePkg::idxMem) &&
                 (opCode[2:0] != dmgCorePkg::idxMem);
      end
      2'b10:
      begin
        decoded.dst = dmgCorePkg::idxA;
        keepOp      = (opCode[2:0] != dmgCorePkg::idxMem) && (opCode[5:3] != 3'b011);
        case (opCode[5:3])
          3'b000:  decoded.aluOp = dmgCorePkg::aluAdd;
          3'b001:  decoded.aluOp = dmgCorePkg::aluAdc;
          3'b010:  decoded.aluOp = dmgCorePkg::aluSub;
          3'b100:  decoded.aluOp = dmgCorePkg::aluAnd;
          3'b101:  decoded.aluOp = dmgCorePkg::aluXor;
          3'b110:  decoded.aluOp = dmgCorePkg::aluOr;
          3'b111:  decoded.aluOp = dmgCorePkg::aluCp;
          default: decoded.aluOp = dmgCorePkg::aluLd;  // SBC, dropped
        endcase
      end
      2'b00:
      begin
        if (opCode[2:1] == 2'b10)
        begin
          decoded.aluOp = opCode[0] ? dmgCorePkg::aluDec : dmgCorePkg::aluInc;
          decoded.src   = opCode[5:3];
          keepOp        = (opCode[5:3] != dmgCorePkg::idxMem);
        end
      end
      default:
        keepOp = 1'b0;
    endcase
    decoded.writeDst   = (decoded.aluOp != dmgCorePkg::aluCp);
    decoded.writeFlags = (decoded.aluOp != dmgCorePkg::aluLd);
  end

  assign opReady = !heldValid || decOut.ready;

  always_ff @(posedge iClock or negedge arstN)
  begin
    if (!arstN)
      heldValid <= 1'b0;
    else if (opReady)
      heldValid <= opValid && keepOp;  // Unsupported bytes vanish here
  end

  always_ff @(posedge iClock)
  begin
    if (opValid && opReady && keepOp)
      heldOp <= decoded;
  end

  assign decOut.valid = heldValid;
  assign decOut.op    = heldOp;

  // Record held until execute takes it
  holdStable: assert property (
    @(posedge iClock) disable iff (!arstN)
    decOut.valid && !decOut.ready |=> decOut.valid && $stable(decOut.op)
  );

endmodule

//--- rtl/dmgExecuteStage.sv
`timescale 1ns/100ps

module dmgExecuteStage
(
  input  logic                iClock,
  input  logic                arstN,
  dmgStageIf.sink             decIn,
  output dmgCorePkg::regIdx_t rdIdxA,
  output dmgCorePkg::regIdx_t rdIdxB,
  output logic                wrEn,
  output dmgCorePkg::regIdx_t wrIdx,
  output logic [7:0]          wrData,
  output logic                flagsWe,
  output logic [7:0]          newFlags,
  input  logic [7:0]          rdDataA,
  input  logic [7:0]          rdDataB,
  input  logic [7:0]          regA,
  input  logic [7:0]          flags,
  output logic                retValid,
  input  logic                retReady,
  output logic [7:0]          retOpcode,
  output logic [7:0]          retResult,
  output logic [7:0]          retFlags
);

  logic       accept;
  logic [7:0] aluResult;
  logic [7:0] aluFlags;

  // Source on port A, destination on port B
  assign rdIdxA = decIn.op.src;
  assign rdIdxB = decIn.op.dst;

  dmgAlu alu
  (
    .op      (decIn.op.aluOp),
    .accIn   (regA),
    .srcIn   (rdDataA),
    .dstIn   (rdDataB),
    .flagsIn (flags),
    .result  (aluResult),
    .flagsOut(aluFlags)
  );

  // ------------------------------------------------------------
  // Commit and retire at the same edge
  // ------------------------------------------------------------
  assign decIn.ready = !retValid || retReady;
  assign accept      = decIn.valid && decIn.ready;

  assign wrEn     = accept && decIn.op.writeDst;
  assign wrIdx    = decIn.op.dst;
  assign wrData   = aluResult;
  assign flagsWe  = accept && decIn.op.writeFlags;
  assign newFlags = aluFlags;

  always_ff @(posedge iClock or negedge arstN)
  begin
    if (!arstN)
      retValid <= 1'b0;
    else if (decIn.ready)
      retValid <= decIn.valid;
  end

  always_ff @(posedge iClock)
  begin
    if (accept)
    begin
      retOpcode <= decIn.op.opcode;
      retResult <= aluResult;
      retFlags  <= aluFlags;  // Equals the old flags for LD
    end
  end

  retireStable: assert property (
    @(posedge iClock) disable iff (!arstN)
    retValid && !retReady |=> retValid && $stable({retOpcode, retResult, retFlags})
  );

endmodule

//--- rtl/dmgRegisterFile.sv
`timescale 1ns/100ps

module dmgRegisterFile
#(
  parameter logic [7:0] pResetFlags = dmgCorePkg::cResetFlags
)
(
  input  logic                iClock,
  input  logic                arstN,
  input  dmgCorePkg::regIdx_t rdIdxA,
  input  dmgCorePkg::regIdx_t rdIdxB,
  input  logic                wrEn,
  input  dmgCorePkg::regIdx_t wrIdx,
  input  logic [7:0]          wrData,
  input  logic                flagsWe,
  input  logic [7:0]          flagsIn,
  output logic [7:0]          rdDataA,
  output logic [7:0]          rdDataB,
  output logic [7:0]          regA,
  output logic [7:0]          flags
);

  logic [7:0] regs [8];  // Slot 6 is never written
  logic [7:0] flagReg;

  always_ff @(posedge iClock or negedge arstN)
  begin
    if (!arstN)
    begin
      for (int i = 0; i < 8; i++)
        regs[i] <= 8'h00;
    end
    else if (wrEn && (wrIdx != dmgCorePkg::idxMem))
    begin
      regs[wrIdx] <= wrData;
    end
  end

  always_ff @(posedge iClock or negedge arstN)
  begin
    if (!arstN)
      flagReg <= pResetFlags;
    else if (flagsWe)
      flagReg <= {flagsIn[7:4], 4'b0000};  // Low nibble stays zero
  end

  assign rdDataA = regs[rdIdxA];
  assign rdDataB = regs[rdIdxB];
  assign regA    = regs[dmgCorePkg::idxA];
  assign flags   = flagReg;

  // Decode never lets an (HL) form through
  noMemWrite: assert property (
    @(posedge iClock) disable iff (!arstN)
    wrEn |-> wrIdx != dmgCorePkg::idxMem
  );

endmodule

//--- rtl/dmgStageIf.sv
`timescale 1ns/100ps

// Decode to execute link
interface dmgStageIf;

  logic                   valid;
  logic                   ready;
  dmgCorePkg::decodedOp_t op;

  modport source
  (
    output valid,
    output op,
    input  ready
  );

  modport sink
  (
    input  valid,
    input  op,
    output ready
  );

endinterface

//--- testbench/dmgCoreModel.svh
`ifndef DMG_CORE_MODEL_SVH
`define DMG_CORE_MODEL_SVH

// Model state, index 7 is A and slot 6 stays unused
logic [7:0] modelRegs [8];
logic [7:0] modelFlags;

function automatic void resetModel();
  for (int i = 0; i < 8; i++)
    modelRegs[i] = 8'h00;
  modelFlags = 8'hB0;
endfunction

// True for the opcodes the core retires
function automatic bit opKept(input logic [7:0] opc);
  case (opc[7:6])
    2'b01:   return (opc[5:3] != 3'd6) && (opc[2:0] != 3'd6);
    2'b10:   return (opc[2:0] != 3'd6) && (opc[5:3] != 3'd3);  // No SBC
    2'b00:   return (opc[2:1] == 2'b10) && (opc[5:3] != 3'd6);
    default: return 1'b0;
  endcase
endfunction

// ------------------------------------------------------------
// One kept opcode on the model, returns {result, flags}
// ------------------------------------------------------------
function automatic logic [15:0] stepModel(input logic [7:0] opc);
  logic [2:0] d;
  logic [2:0] s;
  logic [7:0] res;
  logic       z;
  logic       n;
  logic       h;
  logic       c;
  int         a;
  int         v;
  int         cin;
  d = opc[5:3];
  s = opc[2:0];
  {z, n, h, c} = modelFlags[7:4];
  if (opc[7:6] == 2'b01)
  begin
    res          = modelRegs[s];
    modelRegs[d] = res;
    return {res, modelFlags};  // Flags untouched
  end
  if (opc[7:6] == 2'b00)
  begin
    res = opc[0] ? modelRegs[d] - 8'd1 : modelRegs[d] + 8'd1;
    n   = opc[0];
    h   = opc[0] ? (res[3:0] == 4'hF) : (res[3:0] == 4'h0);
    modelRegs[d] = res;
  end
  else
  begin
    a   = modelRegs[7];
    v   = modelRegs[s];
    cin = (d == 3'd1) ? int'(c) : 0;
    case (d)
      3'd0, 3'd1:
      begin
        res = 8'(a + v + cin);
        n   = 1'b0;
        h   = ((a % 16) + (v % 16) + cin) > 15;
        c   = (a + v + cin) > 255;
      end
      3'd2, 3'd7:
      begin
        res = 8'(a - v);
        n   = 1'b1;
        h   = (v % 16) > (a % 16);  // Borrow from the high nibble
        c   = v > a;
      end
      3'd4:    {res, n, h, c} = {8'(a & v), 3'b010};
      3'd5:    {res, n, h, c} = {8'(a ^ v), 3'b000};
      default: {res, n, h, c} = {8'(a | v), 3'b000};
    endcase
    if (d != 3'd7)
      modelRegs[7] = res;  // CP leaves A alone
  end
  z          = (res == 8'h00);
  modelFlags = {z, n, h, c, 4'b0000};
  return {res, modelFlags};
endfunction

`endif

//--- testbench/tbDmgCore.sv
`timescale 1ns/100ps

module tbDmgCore;

  localparam int          cPeriodNs    = 8;
  localparam logic [31:0] cSeed        = 32'h8eac;
  localparam int          cMoveRounds  = 20;   // 4 opcodes each
  localparam int          cArithOps    = 200;  // Up to 2 opcodes each
  localparam int          cLogicRounds = 60;   // 2 opcodes each
  localparam int          cRandomOps   = 300;
  localparam int          cPressureOps = 300;
  localparam int          cTotalOps    = 1 + 4 * cMoveRounds + 2 * cArithOps +
                                         2 * cLogicRounds + cRandomOps + cPressureOps;
  localparam int          cTimeoutNs   = (16 + 20 * cTotalOps) * cPeriodNs;

  logic       iClock;
  logic       arstN;
  logic       opValid;
  logic       opReady;
  logic [7:0] opCode;
  logic       retValid;
  logic       retReady;
  logic [7:0] retOpcode;
  logic [7:0] retResult;
  logic [7:0] retFlags;

  logic [23:0] expected [$];  // {opcode, result, flags}
  bit          bpMode;
  bit          sawStall;
  int          valueErrors;
  int          otherErrors;
  int          sentCount;
  int          keptCount;
  int          retiredCount;

  `include "dmgCoreModel.svh"

  dmgCoreTop #(.pResetFlags(dmgCorePkg::cResetFlags)) i_dut
  (
    .iClock   (iClock),
    .arstN    (arstN),
    .opValid  (opValid),
    .opReady  (opReady),
    .opCode   (opCode),
    .retValid (retValid),
    .retReady (retReady),
    .retOpcode(retOpcode),
    .retResult(retResult),
    .retFlags (retFlags)
  );

  initial iClock = 1'b0;
  always #(cPeriodNs / 2) iClock = ~iClock;

  // ------------------------------------------------------------
  // Opcode builders
  // ------------------------------------------------------------
  function automatic logic [2:0] pickReg();
    logic [2:0] r;
    r = 3'($urandom_range(0, 6));
    return (r == 3'd6) ? 3'd7 : r;
  endfunction

  function automatic logic [7:0] ldOp(input logic [2:0] dst, input logic [2:0] src);
    return {2'b01, dst, src};
  endfunction

  function automatic logic [7:0] incDecOp(input logic [2:0] r, input logic isDec);
    return {2'b00, r, 2'b10, isDec};
  endfunction

  function automatic logic [7:0] accOp(input logic [2:0] code, input logic [2:0] src);
    return {2'b10, code, src};
  endfunction

  // Enters and leaves on a falling edge
  task automatic sendOp(input logic [7:0] opc);
    opValid = 1'b1;
    opCode  = opc;
    #2;
    while (!opReady)
    begin
      @(negedge iClock);
      #2;
    end
    @(negedge iClock);
    opValid = 1'b0;
    sentCount++;
    if (opKept(opc))
    begin
      expected.push_back({opc, stepModel(opc)});
      keptCount++;
    end
  endtask

  task automatic waitDrain();
    while (expected.size() != 0)
      @(negedge iClock);
    repeat (4) @(negedge iClock);
  endtask

  task automatic compareValue(input string name, input logic [7:0] exp, input logic [7:0] act);
    if (act !== exp)
    begin
      $display("FAIL %0t %s expected %02h actual %02h", $time, name, exp, act);
      valueErrors++;
    end
  endtask

  task automatic checkRetire();
    logic [23:0] rec;
    retiredCount++;
    if (expected.size() == 0)
    begin
      $display("Opcode %02h retired at %0t with no kept opcode outstanding", retOpcode, $time);
      otherErrors++;
    end
    else
    begin
      rec = expected.pop_front();
      compareValue("retOpcode", rec[23:16], retOpcode);
      compareValue("retResult", rec[15:8], retResult);
      compareValue("retFlags", rec[7:0], retFlags);
    end
  endtask

  // ------------------------------------------------------------
  // Retire handshake sampled between edges
  // ------------------------------------------------------------
  initial
  begin
    retReady = 1'b1;
    forever
    begin
      @(negedge iClock);
      retReady = bpMode ? ($urandom_range(0, 1) == 1) : 1'b1;
      #2;
      if (bpMode && !opReady)
        sawStall = 1'b1;
      if (retValid && retReady)
        checkRetire();
    end
  end

  initial
  begin
    #(cTimeoutNs);
    $display("Timeout after %0d ns with %0d records still expected", cTimeoutNs, expected.size());
    $display("Some tests failed");
    $finish;
  end

  initial
  begin
    logic [2:0]  src;
    logic [2:0]  dst;
    logic [2:0]  code;
    logic [7:0]  opc;
    void'($urandom(cSeed));
    arstN    = 1'b0;
    opValid  = 1'b0;
    opCode   = 8'h00;
    resetModel();
    repeat (16) @(negedge iClock);
    arstN = 1'b1;

    // Reset state, then LD A,A
    repeat (4)
    begin
      @(negedge iClock);
      #2;
      if (retValid)
      begin
        $display("retValid went high at %0t without any opcode sent", $time);
        otherErrors++;
      end
    end
    @(negedge iClock);
    sendOp(8'h7F);

    for (int i = 0; i < cMoveRounds; i++)
    begin
      src = pickReg();
      sendOp(incDecOp(src, 1'($urandom_range(0, 1))));
      repeat (3)
      begin
        dst = pickReg();
        sendOp(ldOp(dst, src));
        src = dst;
      end
    end

    for (int i = 0; i < cArithOps; i++)
    begin
      case ($urandom_range(0, 5))
        0:       opc = accOp(3'b000, pickReg());
        1:       opc = accOp(3'b001, pickReg());
        2:       opc = accOp(3'b010, pickReg());
        3:       opc = accOp(3'b111, pickReg());
        4:       opc = incDecOp(pickReg(), 1'b0);
        default: opc = incDecOp(pickReg(), 1'b1);
      endcase
      sendOp(opc);
      if (opc[7:3] == 5'b10111)
        sendOp(ldOp(3'd0, 3'd7));  // LD B,A shows A after CP
    end

    for (int i = 0; i < cLogicRounds; i++)
    begin
      sendOp(incDecOp(pickReg(), 1'($urandom_range(0, 1))));
      code = 3'($urandom_range(4, 6));
      sendOp(accOp(code, pickReg()));
    end

    for (int i = 0; i < cRandomOps; i++)
    begin
      sendOp(8'($urandom_range(0, 255)));
      if ($urandom_range(0, 7) == 0)
        @(negedge iClock);  // Occasional idle cycle
    end
    waitDrain();

    // Mode switches away from the falling edge where retReady is driven
    @(posedge iClock);
    bpMode = 1'b1;
    @(negedge iClock);
    for (int i = 0; i < cPressureOps; i++)
    begin
      if ($urandom_range(0, 3) == 0)
        sendOp(8'($urandom_range(0, 255)));
      else
        sendOp(accOp(3'($urandom_range(0, 7)), pickReg()));
    end
    waitDrain();
    @(posedge iClock);
    bpMode = 1'b0;
    repeat (4) @(negedge iClock);

    if (!sawStall)
    begin
      $display("opReady never fell while the retire side was stalled");
      otherErrors++;
    end
    if (retiredCount != keptCount)
    begin
      $display("%0d opcodes retired but %0d kept opcodes were sent", retiredCount, keptCount);
      otherErrors++;
    end

    $display("Sent %0d, kept %0d, retired %0d, value errors %0d, other errors %0d",
             sentCount, keptCount, retiredCount, valueErrors, otherErrors);
    if (valueErrors == 0 && otherErrors == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

endmodule
